// ==== Makefile ====
# Verilator build and run for the tic-tac-toe controller

VERILATOR  ?= verilator
TOP        ?= tb_ttt_game
LINT_TOP   ?= ttt_game
FILELIST   ?= ttt_game.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Done: no errors

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/board_store.sv ====
`timescale 1ns/1ps

module board_store (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   move_req,
    input  logic [3:0]             move_cell,
    output logic                   move_ack,
    output ttt_board_pkg::board_u  board,
    output ttt_board_pkg::player_t turn
);

    ttt_board_pkg::cell_t mark;

    assign mark = (turn == ttt_board_pkg::PLAYER_X) ? ttt_board_pkg::MARK_X
                                                    : ttt_board_pkg::MARK_O;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            move_ack    <= 1'b0;
            board.cells <= {ttt_board_pkg::NUM_CELLS{ttt_board_pkg::EMPTY}};
            turn        <= ttt_board_pkg::PLAYER_X;
        end else if (move_req && !move_ack) begin
            // New request, the cell was checked empty upstream
            move_ack               <= 1'b1;
            board.cells[move_cell] <= mark;
            if (turn == ttt_board_pkg::PLAYER_X) begin
                turn <= ttt_board_pkg::PLAYER_O;
            end else begin
                turn <= ttt_board_pkg::PLAYER_X;
            end
        end else if (!move_req && move_ack) begin
            move_ack <= 1'b0;
        end
    end

endmodule

// ==== hdl/cursor_ctrl.sv ====
`timescale 1ns/1ps

module cursor_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [5:0]            key_pulse,
    input  ttt_board_pkg::board_u board,
    input  logic                  game_over,
    input  logic                  move_ack,
    output logic                  move_req,
    output logic [3:0]            move_cell,
    output logic [3:0]            cursor,
    output logic [8:0]            cursor_onehot
);

    localparam logic [1:0] S_MOVE = 2'd0;
    localparam logic [1:0] S_WAIT = 2'd1;
    localparam logic [1:0] S_REQ  = 2'd2;

    localparam logic [3:0] ROW_STEP = 4'(ttt_keys_pkg::GRID_W);
    localparam logic [3:0] LAST_COL = 4'(ttt_keys_pkg::GRID_W - 1);
    localparam logic [3:0] LAST_ROW_START =
        4'(ttt_board_pkg::NUM_CELLS - ttt_keys_pkg::GRID_W);

    logic [1:0] state;
    logic       req_done;
    logic       cell_empty;
    logic       up_ok;
    logic       down_ok;
    logic       left_ok;
    logic       right_ok;
    logic       select_ok;

    assign cell_empty = (board.cells[cursor] == ttt_board_pkg::EMPTY);

    // Edge checks so the cursor never leaves the grid
    assign up_ok    = cursor >= ROW_STEP;
    assign down_ok  = cursor < LAST_ROW_START;
    assign left_ok  = (cursor % ROW_STEP) != 4'd0;
    assign right_ok = (cursor % ROW_STEP) != LAST_COL;

    assign select_ok = (state == S_MOVE) && key_pulse[ttt_keys_pkg::KEY_SPACE] &&
                       (key_pulse[3:0] == 4'd0) && cell_empty && !game_over;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= S_MOVE;
            cursor        <= '0;
            cursor_onehot <= 9'd1;
            move_req      <= 1'b0;
            req_done      <= 1'b0;
        end else begin
            case (state)
                S_MOVE: begin
                    if (key_pulse[ttt_keys_pkg::KEY_UP] && up_ok) begin
                        cursor        <= cursor - ROW_STEP;
                        cursor_onehot <= cursor_onehot >> ttt_keys_pkg::GRID_W;
                    end else if (key_pulse[ttt_keys_pkg::KEY_DOWN] && down_ok) begin
                        cursor        <= cursor + ROW_STEP;
                        cursor_onehot <= cursor_onehot << ttt_keys_pkg::GRID_W;
                    end else if (key_pulse[ttt_keys_pkg::KEY_LEFT] && left_ok) begin
                        cursor        <= cursor - 4'd1;
                        cursor_onehot <= cursor_onehot >> 1;
                    end else if (key_pulse[ttt_keys_pkg::KEY_RIGHT] && right_ok) begin
                        cursor        <= cursor + 4'd1;
                        cursor_onehot <= cursor_onehot << 1;
                    end else if (select_ok) begin
                        state <= S_WAIT;
                    end
                end

                S_WAIT: begin
                    // Cursor stays put until confirm or cancel
                    if (key_pulse[ttt_keys_pkg::KEY_ENTER]) begin
                        state <= S_REQ;
                    end else if (key_pulse[ttt_keys_pkg::KEY_SPACE]) begin
                        state <= S_MOVE;
                    end
                end

                S_REQ: begin
                    if (move_req) begin
                        if (move_ack) begin
                            move_req <= 1'b0;
                            req_done <= 1'b1;
                        end
                    end else if (req_done) begin
                        state    <= S_MOVE;
                        req_done <= 1'b0;
                    end else if (!move_ack) begin
                        // Previous ack has dropped, open a new request
                        move_req <= 1'b1;
                    end
                end

                default: state <= S_MOVE;
            endcase
        end
    end

    // Target cell, held for the whole handshake
    always_ff @(posedge clk) begin
        if (select_ok) begin
            move_cell <= cursor;
        end
    end

endmodule

// ==== hdl/key_edge_detect.sv ====
`timescale 1ns/1ps

module key_edge_detect (
    input  logic       clk,
    input  logic       reset,
    input  logic [5:0] keys,
    output logic [5:0] key_pulse
);

    logic [5:0] keys_sync;
    logic [5:0] keys_prev;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            keys_sync <= '0;
            keys_prev <= '0;
        end else begin
            keys_sync <= keys;
            keys_prev <= keys_sync;
        end
    end

    // High for one cycle after a key goes from released to pressed
    assign key_pulse = keys_sync & ~keys_prev;

endmodule

// ==== hdl/ttt_board_pkg.sv ====
package ttt_board_pkg;

    // Fixed by the game
    localparam int NUM_CELLS = 9;

    // Cell contents, code 2'b11 is never written
    typedef enum logic [1:0] {
        EMPTY  = 2'b00,
        MARK_X = 2'b01,
        MARK_O = 2'b10
    } cell_t;

    typedef enum logic {
        PLAYER_X = 1'b0,
        PLAYER_O = 1'b1
    } player_t;

    // Same 18 bits seen as cells or as rows
    // Cell 0 is top left and sits in the low bits, so rows[0] is the top row
    typedef union packed {
        cell_t [NUM_CELLS-1:0] cells;
        logic  [2:0][5:0]      rows;
    } board_u;

    typedef enum logic [1:0] {
        NONE   = 2'b00,
        X_WINS = 2'b01,
        O_WINS = 2'b10,
        DRAW   = 2'b11
    } result_t;

endpackage

// ==== hdl/ttt_game.sv ====
`timescale 1ns/1ps

module ttt_game (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [5:0]             keys,
    output ttt_board_pkg::board_u  board,
    output logic [3:0]             cursor,
    output logic [8:0]             cursor_onehot,
    output ttt_board_pkg::player_t turn,
    output ttt_board_pkg::result_t result,
    output logic                   game_over
);

    logic [5:0] key_pulse;
    logic       move_req;
    logic       move_ack;
    logic [3:0] move_cell;

    key_edge_detect u_key_edge_detect (
        .clk       (clk),
        .reset     (reset),
        .keys      (keys),
        .key_pulse (key_pulse)
    );

    cursor_ctrl u_cursor_ctrl (
        .clk           (clk),
        .reset         (reset),
        .key_pulse     (key_pulse),
        .board         (board),
        .game_over     (game_over),
        .move_ack      (move_ack),
        .move_req      (move_req),
        .move_cell     (move_cell),
        .cursor        (cursor),
        .cursor_onehot (cursor_onehot)
    );

    // Always ready, so a move only waits on the handshake
    board_store u_board_store (
        .clk       (clk),
        .reset     (reset),
        .move_req  (move_req),
        .move_cell (move_cell),
        .move_ack  (move_ack),
        .board     (board),
        .turn      (turn)
    );

    win_detect u_win_detect (
        .clk       (clk),
        .reset     (reset),
        .board     (board),
        .result    (result),
        .game_over (game_over)
    );

endmodule

// ==== hdl/ttt_keys_pkg.sv ====
package ttt_keys_pkg;

    // Bit positions in the key vector
    localparam int KEY_UP    = 0;
    localparam int KEY_DOWN  = 1;
    localparam int KEY_LEFT  = 2;
    localparam int KEY_RIGHT = 3;
    localparam int KEY_SPACE = 4;
    localparam int KEY_ENTER = 5;

    // Cells per cursor row
    localparam int GRID_W = 3;

endpackage

// ==== hdl/win_detect.sv ====
`timescale 1ns/1ps

module win_detect (
    input  logic                   clk,
    input  logic                   reset,
    input  ttt_board_pkg::board_u  board,
    output ttt_board_pkg::result_t result,
    output logic                   game_over
);

    ttt_board_pkg::result_t win;
    ttt_board_pkg::result_t next_result;
    logic                   full;

    function automatic ttt_board_pkg::result_t line_result(
        input ttt_board_pkg::cell_t a,
        input ttt_board_pkg::cell_t b,
        input ttt_board_pkg::cell_t c
    );
        line_result = ttt_board_pkg::NONE;
        if (a == b && b == c) begin
            if (a == ttt_board_pkg::MARK_X) begin
                line_result = ttt_board_pkg::X_WINS;
            end else if (a == ttt_board_pkg::MARK_O) begin
                line_result = ttt_board_pkg::O_WINS;
            end
        end
    endfunction

    always_comb begin
        win = ttt_board_pkg::NONE;
        // Rows straight from the row view
        for (int r = 0; r < 3; r++) begin
            if (win == ttt_board_pkg::NONE) begin
                win = line_result(ttt_board_pkg::cell_t'(board.rows[r][1:0]),
                                  ttt_board_pkg::cell_t'(board.rows[r][3:2]),
                                  ttt_board_pkg::cell_t'(board.rows[r][5:4]));
            end
        end
        for (int c = 0; c < 3; c++) begin
            if (win == ttt_board_pkg::NONE) begin
                win = line_result(board.cells[c], board.cells[c+3], board.cells[c+6]);
            end
        end
        if (win == ttt_board_pkg::NONE) begin
            win = line_result(board.cells[0], board.cells[4], board.cells[8]);
        end
        if (win == ttt_board_pkg::NONE) begin
            win = line_result(board.cells[2], board.cells[4], board.cells[6]);
        end
    end

    always_comb begin
        full = 1'b1;
        for (int i = 0; i < ttt_board_pkg::NUM_CELLS; i++) begin
            if (board.cells[i] == ttt_board_pkg::EMPTY) begin
                full = 1'b0;
            end
        end
    end

    assign next_result = (win != ttt_board_pkg::NONE) ? win :
                         full ? ttt_board_pkg::DRAW : ttt_board_pkg::NONE;

    // First result sticks until reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= ttt_board_pkg::NONE;
        end else if (result == ttt_board_pkg::NONE) begin
            result <= next_result;
        end
    end

    assign game_over = (result != ttt_board_pkg::NONE);

endmodule

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 5;
    localparam int RESET_CYCLES   = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== tb/tb_ttt_game.sv ====
`timescale 1ns/1ps

module tb_ttt_game;

    localparam int SCRIPT_PRESSES = 300;
    localparam int RAND_GAMES     = 4;
    localparam int RAND_PRESSES   = 80;
    // Enter press is the longest, 4 cycles of key plus 6 of settling
    localparam int PRESS_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES =
        (SCRIPT_PRESSES + RAND_GAMES * RAND_PRESSES) * PRESS_CYCLES + 200;

    // Cell triples of the eight lines
    localparam int WIN_LINES [24] = '{0, 1, 2, 3, 4, 5, 6, 7, 8,
                                      0, 3, 6, 1, 4, 7, 2, 5, 8,
                                      0, 4, 8, 2, 4, 6};

    logic                   clk;
    logic                   por_reset;
    logic                   game_reset;
    logic                   dut_reset;
    logic [5:0]             keys;
    ttt_board_pkg::board_u  board;
    logic [3:0]             cursor;
    logic [8:0]             cursor_onehot;
    ttt_board_pkg::player_t turn;
    ttt_board_pkg::result_t result;
    logic                   game_over;

    // Reference model state
    int                     exp_cursor;
    ttt_board_pkg::board_u  exp_board;
    ttt_board_pkg::player_t exp_turn;
    ttt_board_pkg::result_t exp_result;
    bit                     exp_waiting;

    logic [7:0] lfsr_state;
    int         errors;
    int         checks;
    event       settled;

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (por_reset)
    );

    assign dut_reset = por_reset | game_reset;

    ttt_game u_ttt_game (
        .clk           (clk),
        .reset         (dut_reset),
        .keys          (keys),
        .board         (board),
        .cursor        (cursor),
        .cursor_onehot (cursor_onehot),
        .turn          (turn),
        .result        (result),
        .game_over     (game_over)
    );

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        // Taps 8, 6, 5, 4
        lfsr_next = {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic ttt_board_pkg::result_t board_result(input ttt_board_pkg::board_u b);
        ttt_board_pkg::cell_t first;
        bit                   full;
        board_result = ttt_board_pkg::NONE;
        for (int l = 0; l < 8; l++) begin
            first = b.cells[WIN_LINES[3*l]];
            if (board_result == ttt_board_pkg::NONE && first != ttt_board_pkg::EMPTY &&
                b.cells[WIN_LINES[3*l+1]] == first && b.cells[WIN_LINES[3*l+2]] == first) begin
                board_result = (first == ttt_board_pkg::MARK_X) ? ttt_board_pkg::X_WINS
                                                                 : ttt_board_pkg::O_WINS;
            end
        end
        full = 1'b1;
        for (int i = 0; i < ttt_board_pkg::NUM_CELLS; i++) begin
            if (b.cells[i] == ttt_board_pkg::EMPTY) begin
                full = 1'b0;
            end
        end
        if (board_result == ttt_board_pkg::NONE && full) begin
            board_result = ttt_board_pkg::DRAW;
        end
    endfunction

    function automatic void reset_model();
        exp_cursor  = 0;
        exp_board   = '0;
        exp_turn    = ttt_board_pkg::PLAYER_X;
        exp_result  = ttt_board_pkg::NONE;
        exp_waiting = 1'b0;
    endfunction

    // Expected effect of one key press
    function automatic void apply_key(input int key);
        if (exp_waiting) begin
            if (key == ttt_keys_pkg::KEY_ENTER) begin
                exp_board.cells[exp_cursor] = (exp_turn == ttt_board_pkg::PLAYER_X) ?
                                              ttt_board_pkg::MARK_X : ttt_board_pkg::MARK_O;
                exp_turn = (exp_turn == ttt_board_pkg::PLAYER_X) ? ttt_board_pkg::PLAYER_O
                                                                  : ttt_board_pkg::PLAYER_X;
                if (exp_result == ttt_board_pkg::NONE) begin
                    exp_result = board_result(exp_board);
                end
                exp_waiting = 1'b0;
            end else if (key == ttt_keys_pkg::KEY_SPACE) begin
                exp_waiting = 1'b0;
            end
        end else begin
            case (key)
                ttt_keys_pkg::KEY_UP: begin
                    if (exp_cursor >= ttt_keys_pkg::GRID_W) begin
                        exp_cursor -= ttt_keys_pkg::GRID_W;
                    end
                end
                ttt_keys_pkg::KEY_DOWN: begin
                    if (exp_cursor < ttt_board_pkg::NUM_CELLS - ttt_keys_pkg::GRID_W) begin
                        exp_cursor += ttt_keys_pkg::GRID_W;
                    end
                end
                ttt_keys_pkg::KEY_LEFT: begin
                    if (exp_cursor % ttt_keys_pkg::GRID_W != 0) begin
                        exp_cursor -= 1;
                    end
                end
                ttt_keys_pkg::KEY_RIGHT: begin
                    if (exp_cursor % ttt_keys_pkg::GRID_W != ttt_keys_pkg::GRID_W - 1) begin
                        exp_cursor += 1;
                    end
                end
                ttt_keys_pkg::KEY_SPACE: begin
                    if (exp_board.cells[exp_cursor] == ttt_board_pkg::EMPTY &&
                        exp_result == ttt_board_pkg::NONE) begin
                        exp_waiting = 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    endfunction

    task automatic press(input int key);
        @(posedge clk);
        keys <= 6'd1 << key;
        repeat (2) @(posedge clk);
        keys <= '0;
        repeat (2) @(posedge clk);
        if (key == ttt_keys_pkg::KEY_ENTER) begin
            repeat (6) @(posedge clk);
        end
        apply_key(key);
        @(negedge clk);
        -> settled;
    endtask

    task automatic restart_game();
        @(posedge clk);
        game_reset <= 1'b1;
        repeat (2) @(posedge clk);
        game_reset <= 1'b0;
        reset_model();
        @(negedge clk);
        -> settled;
    endtask

    task automatic move_to(input int target);
        while (exp_cursor / ttt_keys_pkg::GRID_W > target / ttt_keys_pkg::GRID_W) begin
            press(ttt_keys_pkg::KEY_UP);
        end
        while (exp_cursor / ttt_keys_pkg::GRID_W < target / ttt_keys_pkg::GRID_W) begin
            press(ttt_keys_pkg::KEY_DOWN);
        end
        while (exp_cursor > target) begin
            press(ttt_keys_pkg::KEY_LEFT);
        end
        while (exp_cursor < target) begin
            press(ttt_keys_pkg::KEY_RIGHT);
        end
    endtask

    // One hex digit per move, first move in the top digit
    task automatic play_moves(input logic [35:0] seq, input int count);
        for (int i = 0; i < count; i++) begin
            move_to(int'(seq[35 - 4*i -: 4]));
            press(ttt_keys_pkg::KEY_SPACE);
            press(ttt_keys_pkg::KEY_ENTER);
        end
    endtask

    task automatic check_outputs();
        checks += 6;
        assert (int'(cursor) == exp_cursor) else begin
            errors++;
            $display("ERROR %0t: cursor is %0d, expected %0d", $time, cursor, exp_cursor);
        end
        assert (cursor_onehot == (9'd1 << exp_cursor)) else begin
            errors++;
            $display("ERROR %0t: cursor_onehot is %b for cursor %0d", $time,
                     cursor_onehot, exp_cursor);
        end
        assert (board == exp_board) else begin
            errors++;
            $display("ERROR %0t: board is %h, expected %h", $time, board.rows, exp_board.rows);
        end
        assert (turn == exp_turn) else begin
            errors++;
            $display("ERROR %0t: turn is %0d, expected %0d", $time, turn, exp_turn);
        end
        assert (result == exp_result) else begin
            errors++;
            $display("ERROR %0t: result is %0d, expected %0d", $time, result, exp_result);
        end
        assert (game_over == (exp_result != ttt_board_pkg::NONE)) else begin
            errors++;
            $display("ERROR %0t: game_over is %0b with result %0d", $time, game_over, exp_result);
        end
    endtask

    task automatic finish_run(input bit timed_out);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        forever begin
            @(settled);
            check_outputs();
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: tests still running after %0d cycles, run stopped", TIMEOUT_CYCLES);
        finish_run(1'b1);
    end

    initial begin
        int pick;
        keys       = '0;
        game_reset = 1'b0;
        lfsr_state = 8'd56;
        errors     = 0;
        checks     = 0;
        reset_model();
        wait (por_reset === 1'b0);
        @(negedge clk);
        -> settled;

        // Walk the border, bumping every edge, then the centre
        press(ttt_keys_pkg::KEY_UP);
        press(ttt_keys_pkg::KEY_LEFT);
        repeat (3) press(ttt_keys_pkg::KEY_RIGHT);
        repeat (3) press(ttt_keys_pkg::KEY_DOWN);
        repeat (3) press(ttt_keys_pkg::KEY_LEFT);
        repeat (3) press(ttt_keys_pkg::KEY_UP);
        press(ttt_keys_pkg::KEY_RIGHT);
        press(ttt_keys_pkg::KEY_DOWN);

        // Place, occupied select, cancel, frozen cursor in WAIT
        press(ttt_keys_pkg::KEY_SPACE);
        press(ttt_keys_pkg::KEY_ENTER);
        press(ttt_keys_pkg::KEY_SPACE);
        press(ttt_keys_pkg::KEY_ENTER);
        press(ttt_keys_pkg::KEY_RIGHT);
        press(ttt_keys_pkg::KEY_SPACE);
        press(ttt_keys_pkg::KEY_SPACE);
        press(ttt_keys_pkg::KEY_DOWN);
        press(ttt_keys_pkg::KEY_SPACE);
        press(ttt_keys_pkg::KEY_UP);
        press(ttt_keys_pkg::KEY_ENTER);

        // Row win for X, column win for O, diagonal, then a draw
        restart_game();
        play_moves(36'h031428000, 6);
        restart_game();
        play_moves(36'h013487500, 7);
        restart_game();
        play_moves(36'h204168000, 6);
        restart_game();
        play_moves(36'h012435768, 9);

        for (int g = 0; g < RAND_GAMES; g++) begin
            restart_game();
            for (int p = 0; p < RAND_PRESSES; p++) begin
                random_bits(3, pick);
                // Codes 6 and 7 fold onto space and enter
                if (pick >= 6) begin
                    pick = pick - 2;
                end
                press(pick);
            end
        end

        repeat (2) @(posedge clk);
        finish_run(1'b0);
    end

endmodule

// ==== ttt_game.f ====
hdl/ttt_board_pkg.sv
hdl/ttt_keys_pkg.sv
hdl/key_edge_detect.sv
hdl/cursor_ctrl.sv
hdl/board_store.sv
hdl/win_detect.sv
hdl/ttt_game.sv
tb/clock_gen.sv
tb/tb_ttt_game.sv
